// File: src/adc_monitor_pkg.sv
// ADC monitor package with the I2C target constants and shared bus types
package adc_monitor_pkg;

    // ----------------------------------------
    // I2C target
    // ----------------------------------------
    localparam logic [6:0] I2C_DEV_ADDR = 7'h50;

    // ----------------------------------------
    // ADC channels
    // ----------------------------------------
    localparam int ADC_NUM_CH    = 5;
    localparam int ADC_SAMPLE_W  = 12;
    localparam int ADC_RESP_CH_W = 5;

    // Entry n is the ADC channel number behind published channel n
    localparam logic [ADC_NUM_CH-1:0][ADC_RESP_CH_W-1:0] ADC_CH_MAP = {
        5'd6, 5'd4, 5'd3, 5'd2, 5'd1
    };

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [7:0] DEVICE_ID      = 8'hAF;
    localparam logic [6:0] CTRL_TAG       = 7'd1;
    localparam int         REG_BYTE_COUNT = 12;
    localparam int         REG_PTR_W      = 3;
    localparam int         BYTE_ADDR_W    = 4;

    // One beat of the ADC response stream
    typedef struct packed {
        logic                     valid;
        logic [ADC_RESP_CH_W-1:0] channel;
        logic [ADC_SAMPLE_W-1:0]  data;
        logic                     sop;
        logic                     eop;
    } adc_beat_t;

    // Decoded bus activity, all pulses except sda
    typedef struct packed {
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
        logic sda;
    } i2c_event_t;

    // Published sample set, index n is published channel n
    typedef struct packed {
        logic [ADC_NUM_CH-1:0][ADC_SAMPLE_W-1:0] sample;
    } adc_bank_t;

    // Requests from the I2C engine to the register map
    typedef struct packed {
        logic       ptr_load;
        logic       data_write;
        logic       rd_begin;
        logic       rd_fetch;
        logic [7:0] wdata;
    } reg_access_t;

endpackage

// File: src/i2c_line_sampler.sv
// I2C line sampler that synchronizes SCL and SDA and decodes bus events
module i2c_line_sampler import adc_monitor_pkg::*; (
    input  logic       clk_core,
    input  logic       reset_n,
    input  logic       scl,
    input  logic       sda,
    output i2c_event_t bus_event
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_prev;
    logic       sda_prev;

    // Two flop synchronizer plus one stage of history for edge detection
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
            scl_prev <= scl_sync[1];
            sda_prev <= sda_sync[1];
        end
    end

    // ----------------------------------------
    // Registered event decode
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bus_event.start    <= 1'b0;
            bus_event.stop     <= 1'b0;
            bus_event.scl_rise <= 1'b0;
            bus_event.scl_fall <= 1'b0;
            bus_event.sda      <= 1'b1;
        end else begin
            // SDA edges only count while SCL stays high
            bus_event.start    <= sda_prev & ~sda_sync[1] & scl_prev & scl_sync[1];
            bus_event.stop     <= ~sda_prev & sda_sync[1] & scl_prev & scl_sync[1];
            bus_event.scl_rise <= ~scl_prev & scl_sync[1];
            bus_event.scl_fall <= scl_prev & ~scl_sync[1];
            bus_event.sda      <= sda_sync[1];
        end
    end

endmodule

// File: src/i2c_target_engine.sv
// I2C target FSM for framing, address match, ACK generation and read shifting
module i2c_target_engine import adc_monitor_pkg::*; (
    input  logic        clk_core,
    input  logic        reset_n,
    input  i2c_event_t  bus_event,
    input  logic [7:0]  rd_byte,
    output reg_access_t reg_access,
    output logic        sda_drive_low
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_WRITE,
        ST_WR_ACK,
        ST_READ,
        ST_RD_ACK,
        ST_IGNORE
    } engine_state_t;

    engine_state_t state;
    logic [3:0]    bit_cnt;
    logic [7:0]    shift_reg;
    logic          read_mode;
    logic          first_byte;

    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            state         <= ST_IDLE;
            bit_cnt       <= 4'd0;
            shift_reg     <= 8'd0;
            read_mode     <= 1'b0;
            first_byte    <= 1'b0;
            sda_drive_low <= 1'b0;
            reg_access    <= '0;
        end else begin
            // Requests are single cycle pulses
            reg_access.ptr_load   <= 1'b0;
            reg_access.data_write <= 1'b0;
            reg_access.rd_begin   <= 1'b0;
            reg_access.rd_fetch   <= 1'b0;

            if (bus_event.start) begin
                // START and repeated START both restart address framing
                state         <= ST_ADDR;
                bit_cnt       <= 4'd0;
                sda_drive_low <= 1'b0;
            end else if (bus_event.stop) begin
                state         <= ST_IDLE;
                sda_drive_low <= 1'b0;
            end else begin
                case (state)
                    // ----------------------------------------
                    // Address byte and its ACK
                    // ----------------------------------------
                    ST_ADDR: begin
                        if (bus_event.scl_rise) begin
                            shift_reg <= {shift_reg[6:0], bus_event.sda};
                            bit_cnt   <= bit_cnt + 4'd1;
                        end else if (bus_event.scl_fall && bit_cnt == 4'd8) begin
                            if (shift_reg[7:1] == I2C_DEV_ADDR) begin
                                sda_drive_low       <= 1'b1;
                                read_mode           <= shift_reg[0];
                                reg_access.rd_begin <= shift_reg[0];
                                state               <= ST_ADDR_ACK;
                            end else begin
                                // Not for us, stay off the bus
                                state <= ST_IGNORE;
                            end
                        end
                    end

                    ST_ADDR_ACK: begin
                        if (bus_event.scl_rise) begin
                            // Fetch the first read byte during the ACK high phase
                            reg_access.rd_fetch <= read_mode;
                        end else if (bus_event.scl_fall) begin
                            bit_cnt <= 4'd0;
                            if (read_mode) begin
                                shift_reg     <= rd_byte;
                                sda_drive_low <= ~rd_byte[7];
                                state         <= ST_READ;
                            end else begin
                                sda_drive_low <= 1'b0;
                                first_byte    <= 1'b1;
                                state         <= ST_WRITE;
                            end
                        end
                    end

                    // ----------------------------------------
                    // Host to target data
                    // ----------------------------------------
                    ST_WRITE: begin
                        if (bus_event.scl_rise) begin
                            shift_reg <= {shift_reg[6:0], bus_event.sda};
                            bit_cnt   <= bit_cnt + 4'd1;
                        end else if (bus_event.scl_fall && bit_cnt == 4'd8) begin
                            sda_drive_low <= 1'b1;
                            state         <= ST_WR_ACK;
                        end
                    end

                    ST_WR_ACK: begin
                        if (bus_event.scl_rise) begin
                            // First data byte is the register index
                            reg_access.ptr_load   <= first_byte;
                            reg_access.data_write <= ~first_byte;
                            reg_access.wdata      <= shift_reg;
                            first_byte            <= 1'b0;
                        end else if (bus_event.scl_fall) begin
                            sda_drive_low <= 1'b0;
                            bit_cnt       <= 4'd0;
                            state         <= ST_WRITE;
                        end
                    end

                    // ----------------------------------------
                    // Target to host data
                    // ----------------------------------------
                    ST_READ: begin
                        if (bus_event.scl_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (bus_event.scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                // Hand SDA to the host for its ACK
                                sda_drive_low <= 1'b0;
                                state         <= ST_RD_ACK;
                            end else begin
                                shift_reg     <= {shift_reg[6:0], 1'b0};
                                sda_drive_low <= ~shift_reg[6];
                            end
                        end
                    end

                    ST_RD_ACK: begin
                        if (bus_event.scl_rise) begin
                            if (!bus_event.sda) begin
                                reg_access.rd_fetch <= 1'b1;
                            end else begin
                                // Host NACK ends the read
                                state <= ST_IGNORE;
                            end
                        end else if (bus_event.scl_fall) begin
                            shift_reg     <= rd_byte;
                            sda_drive_low <= ~rd_byte[7];
                            bit_cnt       <= 4'd0;
                            state         <= ST_READ;
                        end
                    end

                    default: begin
                        // Idle or ignoring, wait for START or STOP
                        sda_drive_low <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// File: src/adc_sample_capture.sv
// ADC sample capture that sorts response beats and publishes a bank per sequence
module adc_sample_capture import adc_monitor_pkg::*; (
    input  logic      clk_core,
    input  logic      reset_n,
    input  adc_beat_t adc_beat,
    output adc_bank_t bank
);

    logic [ADC_NUM_CH-1:0][ADC_SAMPLE_W-1:0] hold;

    // ----------------------------------------
    // Per channel holding registers
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            hold <= '0;
        end else if (adc_beat.valid) begin
            // Unmapped channel numbers match no entry and are dropped
            for (int i = 0; i < ADC_NUM_CH; i++) begin
                if (adc_beat.channel == ADC_CH_MAP[i]) begin
                    hold[i] <= adc_beat.data;
                end
            end
        end
    end

    // ----------------------------------------
    // Published bank
    // ----------------------------------------
    // All channels change together so a reader sees one sequence only
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bank <= '0;
        end else if (adc_beat.eop) begin
            bank.sample <= hold;
        end
    end

endmodule

// File: src/adc_register_map.sv
// Register map with the ADC control register, register pointer and read byte mux
module adc_register_map import adc_monitor_pkg::*; (
    input  logic        clk_core,
    input  logic        reset_n,
    input  reg_access_t reg_access,
    input  adc_bank_t   bank,
    output logic [7:0]  rd_byte,
    output logic        adc_run
);

    logic [REG_PTR_W-1:0]    reg_ptr;
    logic [BYTE_ADDR_W-1:0]  cursor;
    logic [REG_PTR_W-1:0]    ch_idx;
    logic [ADC_SAMPLE_W-1:0] ch_sample;
    logic [7:0]              byte_sel;

    // ----------------------------------------
    // Pointer, cursor and control bit
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            reg_ptr <= '0;
            cursor  <= '0;
            adc_run <= 1'b0;
        end else begin
            if (reg_access.ptr_load) begin
                reg_ptr <= reg_access.wdata[REG_PTR_W-1:0];
                cursor  <= {reg_access.wdata[REG_PTR_W-1:0], 1'b0};
            end else if (reg_access.rd_begin) begin
                cursor <= {reg_ptr, 1'b0};
            end else if (reg_access.rd_fetch) begin
                cursor <= cursor + 1'b1;
            end

            // Only index 0 is writable
            if (reg_access.data_write && reg_ptr == '0) begin
                adc_run <= reg_access.wdata[0];
            end
        end
    end

    // ----------------------------------------
    // Byte map
    // ----------------------------------------
    always_comb begin
        // Bytes 2 and 3 belong to channel 0, 4 and 5 to channel 1, and so on
        ch_idx = cursor[BYTE_ADDR_W-1:1] - REG_PTR_W'(1);
        if (ch_idx < REG_PTR_W'(ADC_NUM_CH)) begin
            ch_sample = bank.sample[ch_idx];
        end else begin
            ch_sample = '0;
        end

        if (cursor >= BYTE_ADDR_W'(REG_BYTE_COUNT)) begin
            byte_sel = 8'd0;
        end else if (cursor == BYTE_ADDR_W'(0)) begin
            byte_sel = {CTRL_TAG, adc_run};
        end else if (cursor == BYTE_ADDR_W'(1)) begin
            byte_sel = DEVICE_ID;
        end else if (!cursor[0]) begin
            byte_sel = ch_sample[7:0];
        end else begin
            // Upper nibble, zero extended
            byte_sel = 8'(ch_sample[ADC_SAMPLE_W-1:8]);
        end
    end

    // Held until the next fetch
    always_ff @(posedge clk_core) begin
        if (reg_access.rd_fetch) begin
            rd_byte <= byte_sel;
        end
    end

endmodule

// File: src/adc_monitor_top.sv
// ADC monitor top level joining the I2C target path and the ADC capture path
module adc_monitor_top import adc_monitor_pkg::*; (
    input  logic      clk_core,
    input  logic      reset_n,
    input  logic      scl,
    input  logic      sda,
    input  adc_beat_t adc_beat,
    output logic      sda_drive_low,
    output logic      adc_run
);

    i2c_event_t  bus_event;
    reg_access_t reg_access;
    logic [7:0]  rd_byte;
    adc_bank_t   bank;

    // ----------------------------------------
    // I2C path
    // ----------------------------------------
    i2c_line_sampler u_line_sampler (
        .clk_core  (clk_core),
        .reset_n   (reset_n),
        .scl       (scl),
        .sda       (sda),
        .bus_event (bus_event)
    );

    i2c_target_engine u_target_engine (
        .clk_core      (clk_core),
        .reset_n       (reset_n),
        .bus_event     (bus_event),
        .rd_byte       (rd_byte),
        .reg_access    (reg_access),
        .sda_drive_low (sda_drive_low)
    );

    // ----------------------------------------
    // ADC path and register map
    // ----------------------------------------
    adc_sample_capture u_sample_capture (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .adc_beat (adc_beat),
        .bank     (bank)
    );

    adc_register_map u_register_map (
        .clk_core   (clk_core),
        .reset_n    (reset_n),
        .reg_access (reg_access),
        .bank       (bank),
        .rd_byte    (rd_byte),
        .adc_run    (adc_run)
    );

endmodule

// File: tb/tb_clock_gen.sv
// Clock and reset generator for the ADC monitor testbench
module tb_clock_gen (
    output logic clk_core,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk_core = 1'b0;
        forever #50 clk_core = ~clk_core;
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk_core);
        #5 reset_n = 1'b1;
    end

endmodule

// File: tb/tb_adc_monitor.sv
// Testbench for the ADC monitor with an I2C host model and an ADC beat driver
module tb_adc_monitor import adc_monitor_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_core;
    logic        reset_n;
    logic        scl;
    logic        host_sda;
    logic        sda_drive_low;
    logic        adc_run;
    adc_beat_t   adc_beat;
    wire         sda = host_sda & ~sda_drive_low;
    logic [31:0] rng_state;
    logic [11:0] exp_sample [5];
    logic [7:0]  rd_buf [16];
    logic [4:0]  mapped_ch [5] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd6};
    string       cur_test;
    int          test_err;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;

    tb_clock_gen u_clock_gen (.clk_core (clk_core), .reset_n (reset_n));

    adc_monitor_top dut (
        .clk_core      (clk_core),
        .reset_n       (reset_n),
        .scl           (scl),
        .sda           (sda),
        .adc_beat      (adc_beat),
        .sda_drive_low (sda_drive_low),
        .adc_run       (adc_run)
    );

    // Xorshift step giving a fresh 12-bit sample
    function automatic logic [11:0] next_sample();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[11:0];
    endfunction

    // Inputs move 5 ns after the rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk_core);
        #5;
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp,
                              input logic [7:0] act);
        assert (act === exp) else begin
            $display("** Error %s: %s expected 0x%02h, actual 0x%02h",
                     cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        assert (ok) else begin
            $display("%s: %s", cur_test, what);
            test_err++;
        end
    endtask

    // ----------------------------------------
    // I2C host model
    // ----------------------------------------
    // One SCL period of ten cycles low and ten high
    task automatic send_bit(input logic value, output logic seen);
        scl = 1'b0;
        tick(5);
        host_sda = value;
        tick(5);
        scl = 1'b1;
        tick(5);
        seen = sda;
        tick(5);
    endtask

    task automatic bus_start();
        host_sda = 1'b0;
        tick(10);
    endtask

    task automatic bus_stop();
        scl = 1'b0;
        tick(5);
        host_sda = 1'b0;
        tick(5);
        scl = 1'b1;
        tick(5);
        host_sda = 1'b1;
        tick(10);
    endtask

    task automatic write_byte(input logic [7:0] value, output logic acked);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            send_bit(value[i], seen);
        end
        // SDA released so the target can pull it low
        send_bit(1'b1, seen);
        acked = ~seen;
    endtask

    task automatic read_byte(input logic last, output logic [7:0] value);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            send_bit(1'b1, seen);
            value[i] = seen;
        end
        // NACK after the last byte of the burst
        send_bit(last, seen);
    endtask

    task automatic i2c_write(input logic [6:0] addr, input logic [7:0] ptr,
                             input logic with_data, input logic [7:0] data,
                             output int acks);
        logic acked;
        acks = 0;
        bus_start();
        write_byte({addr, 1'b0}, acked);
        acks += int'(acked);
        // Host keeps sending after a NACK
        write_byte(ptr, acked);
        acks += int'(acked);
        if (with_data) begin
            write_byte(data, acked);
            acks += int'(acked);
        end
        bus_stop();
    endtask

    // Read from wherever the index already points
    task automatic read_current(input int count);
        logic acked;
        bus_start();
        write_byte({I2C_DEV_ADDR, 1'b1}, acked);
        check_flag(acked, "read address was not acknowledged");
        for (int k = 0; k < count; k++) begin
            read_byte(k == count - 1, rd_buf[k]);
        end
        bus_stop();
    endtask

    task automatic read_burst(input logic [7:0] ptr, input int count);
        int acks;
        i2c_write(I2C_DEV_ADDR, ptr, 1'b0, 8'h00, acks);
        check_flag(acks == 2, "index write before the read was not acknowledged");
        read_current(count);
    endtask

    task automatic wait_run(input logic exp);
        int cnt;
        cnt = 0;
        while (adc_run !== exp && cnt < 40) begin
            tick(1);
            cnt++;
        end
        check_flag(adc_run === exp,
                   $sformatf("adc_run did not become %0b in 40 cycles", exp));
    endtask

    // ----------------------------------------
    // ADC beat driver
    // ----------------------------------------
    task automatic drive_beat(input logic valid, input logic [4:0] channel,
                              input logic [11:0] data, input logic sop, input logic eop);
        adc_beat.valid   = valid;
        adc_beat.channel = channel;
        adc_beat.data    = data;
        adc_beat.sop     = sop;
        adc_beat.eop     = eop;
        tick(1);
        adc_beat = '0;
    endtask

    // Published channel n sits at index n+1 with the low byte first
    task automatic check_bank();
        for (int n = 0; n < 5; n++) begin
            read_burst(8'(n + 1), 2);
            check_byte("sample low byte", exp_sample[n][7:0], rd_buf[0]);
            check_byte("sample high byte", {4'h0, exp_sample[n][11:8]}, rd_buf[1]);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic end_test();
        $display("%s: %s, %0d errors", cur_test,
                 test_err == 0 ? "passed" : "FAILED", test_err);
        err_cnt += test_err;
        if (test_err == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_values();
        begin_test("reset_values");
        check_byte("adc_run", 8'h00, {7'd0, adc_run});
        // Index is zero out of reset
        read_current(2);
        check_byte("byte 0", {CTRL_TAG, 1'b0}, rd_buf[0]);
        check_byte("byte 1", DEVICE_ID, rd_buf[1]);
        // A new read restarts at the index
        read_current(1);
        check_byte("byte 0 on reread", {CTRL_TAG, 1'b0}, rd_buf[0]);
        end_test();
    endtask

    task automatic test_run_control();
        int acks;
        begin_test("run_control");
        i2c_write(I2C_DEV_ADDR, 8'h00, 1'b1, 8'h01, acks);
        check_flag(acks == 3, "control write of 0x01 was not acknowledged");
        wait_run(1'b1);
        read_burst(8'd0, 1);
        check_byte("byte 0", {CTRL_TAG, 1'b1}, rd_buf[0]);
        i2c_write(I2C_DEV_ADDR, 8'h00, 1'b1, 8'h00, acks);
        check_flag(acks == 3, "control write of 0x00 was not acknowledged");
        wait_run(1'b0);
        end_test();
    endtask

    task automatic test_sample_capture();
        begin_test("sample_capture");
        for (int n = 0; n < 5; n++) begin
            exp_sample[n] = next_sample();
            drive_beat(1'b1, mapped_ch[n], exp_sample[n], n == 0, 1'b0);
        end
        // End of sequence without a sample
        drive_beat(1'b0, 5'd0, 12'd0, 1'b0, 1'b1);
        tick(2);
        check_bank();
        end_test();
    endtask

    task automatic test_ignored_beats();
        begin_test("ignored_beats");
        drive_beat(1'b1, 5'd0, next_sample(), 1'b1, 1'b0);
        drive_beat(1'b1, 5'd5, next_sample(), 1'b0, 1'b0);
        drive_beat(1'b1, 5'd7, next_sample(), 1'b0, 1'b0);
        drive_beat(1'b0, 5'd0, 12'd0, 1'b0, 1'b1);
        tick(2);
        check_bank();
        // New samples without eop stay unpublished
        for (int n = 0; n < 5; n++) begin
            drive_beat(1'b1, mapped_ch[n], next_sample(), n == 0, 1'b0);
        end
        tick(2);
        check_bank();
        end_test();
    endtask

    task automatic test_foreign_address();
        int acks;
        begin_test("foreign_address");
        i2c_write(7'h23, 8'h00, 1'b1, 8'h01, acks);
        check_flag(acks == 0, "target acknowledged a byte sent to address 0x23");
        check_byte("adc_run", 8'h00, {7'd0, adc_run});
        // Index 6 starts at byte 12 just past the map
        read_burst(8'd6, 4);
        for (int k = 0; k < 4; k++) begin
            check_byte("byte past the map", 8'h00, rd_buf[k]);
        end
        end_test();
    endtask

    initial begin
        int cnt;
        scl       = 1'b1;
        host_sda  = 1'b1;
        adc_beat  = '0;
        rng_state = 32'hcd1d_af73;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cnt       = 0;
        while (reset_n !== 1'b1 && cnt < 20) begin
            tick(1);
            cnt++;
        end
        assert (reset_n === 1'b1) else begin
            $display("Reset was not released within 20 cycles");
            err_cnt++;
        end
        tick(2);
        test_reset_values();
        test_run_control();
        test_sample_capture();
        test_ignored_beats();
        test_foreign_address();
        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
src/adc_monitor_pkg.sv
src/i2c_line_sampler.sv
src/i2c_target_engine.sv
src/adc_sample_capture.sv
src/adc_register_map.sv
src/adc_monitor_top.sv
tb/tb_clock_gen.sv
tb/tb_adc_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build the ADC monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_adc_monitor \
    --Mdir obj_dir -o tb_adc_monitor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_adc_monitor_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
